// ==== sim.f ====
+incdir+.
rv32i_types_pkg.sv
ooo_structs_pkg.sv
operand_fetch.sv
cmp_rs.sv
cmp_unit.sv
cmp_cluster.sv
cmp_cluster_checker.sv
tb_cmp_cluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_cmp_cluster
FILELIST  ?= sim.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_cmp_cluster.sv ====
`include "ooo_defs.svh"

module tb_cmp_cluster
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 6;

    logic      clk;
    logic      rst_n_i;
    logic      flush_i;
    logic      disp_valid_i;
    cmp_op_e   disp_op_i;
    rob_tag_t  disp_dst_tag_i;
    logic      disp_src1_ready_i;
    rob_tag_t  disp_src1_tag_i;
    rv32i_word disp_src1_value_i;
    logic      disp_src2_ready_i;
    rob_tag_t  disp_src2_tag_i;
    rv32i_word disp_src2_value_i;
    logic      ext_cdb_valid_i;
    rob_tag_t  ext_cdb_tag_i;
    rv32i_word ext_cdb_value_i;
    logic      full_o;
    logic      cdb_valid_o;
    rob_tag_t  cdb_tag_o;
    rv32i_word cdb_value_o;

    int result_cnt = 0;
    int tb_errs = 0;
    int err_mark;
    int n_pass = 0;
    int n_fail = 0;
    int seen;

    cmp_cluster u_dut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .disp_valid_i      (disp_valid_i),
        .disp_op_i         (disp_op_i),
        .disp_dst_tag_i    (disp_dst_tag_i),
        .disp_src1_ready_i (disp_src1_ready_i),
        .disp_src1_tag_i   (disp_src1_tag_i),
        .disp_src1_value_i (disp_src1_value_i),
        .disp_src2_ready_i (disp_src2_ready_i),
        .disp_src2_tag_i   (disp_src2_tag_i),
        .disp_src2_value_i (disp_src2_value_i),
        .ext_cdb_valid_i   (ext_cdb_valid_i),
        .ext_cdb_tag_i     (ext_cdb_tag_i),
        .ext_cdb_value_i   (ext_cdb_value_i),
        .full_o            (full_o),
        .cdb_valid_o       (cdb_valid_o),
        .cdb_tag_o         (cdb_tag_o),
        .cdb_value_o       (cdb_value_o)
    );

    bind cmp_cluster cmp_cluster_checker u_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst_n_i && cdb_valid_o) begin
            result_cnt <= result_cnt + 1;
        end
    end

    // advance one clock and drop the one-cycle strobes
    task automatic step();
        @(posedge clk);
        disp_valid_i    <= 1'b0;
        ext_cdb_valid_i <= 1'b0;
        flush_i         <= 1'b0;
    endtask

    task automatic dispatch(input cmp_op_e op, input rob_tag_t dst,
        input logic r1, input rob_tag_t t1, input rv32i_word v1,
        input logic r2, input rob_tag_t t2, input rv32i_word v2);
        step();
        while (full_o) begin
            step();
        end
        disp_valid_i      <= 1'b1;
        disp_op_i         <= op;
        disp_dst_tag_i    <= dst;
        disp_src1_ready_i <= r1;
        disp_src1_tag_i   <= t1;
        disp_src1_value_i <= v1;
        disp_src2_ready_i <= r2;
        disp_src2_tag_i   <= t2;
        disp_src2_value_i <= v2;
    endtask

    // same edge as the caller's last drive
    task automatic bcast_now(input rob_tag_t tag, input rv32i_word value);
        ext_cdb_valid_i <= 1'b1;
        ext_cdb_tag_i   <= tag;
        ext_cdb_value_i <= value;
    endtask

    task automatic broadcast(input rob_tag_t tag, input rv32i_word value);
        step();
        bcast_now(tag, value);
    endtask

    task automatic wait_results(input int n);
        int tgt;
        int guard;
        tgt   = result_cnt + n;
        guard = 0;
        while (result_cnt < tgt && guard < 40) begin
            step();
            guard++;
        end
        if (result_cnt < tgt) begin
            tb_errs++;
            $display("timeout at %0t waiting for results, %0d missing", $time,
                tgt - result_cnt);
        end
    endtask

    task automatic open_test();
        err_mark = tb_errs + u_dut.u_checker.fail_cnt;
    endtask

    task automatic close_test(input string name);
        if (u_dut.u_checker.pend_cnt != 0) begin
            tb_errs++;
            $display("%0d operations still wait for a result", u_dut.u_checker.pend_cnt);
        end
        if (tb_errs + u_dut.u_checker.fail_cnt == err_mark) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed", name);
        end
    endtask

    // signed and unsigned corner values with one random slot
    function automatic rv32i_word edge_value();
        case ($urandom() % 6)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            4:       return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    initial begin
        void'($urandom(32));
        clk = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = 1'b0;
        disp_op_i = beq;
        disp_dst_tag_i = '0;
        disp_src1_ready_i = 1'b0;
        disp_src1_tag_i = '0;
        disp_src1_value_i = '0;
        disp_src2_ready_i = 1'b0;
        disp_src2_tag_i = '0;
        disp_src2_value_i = '0;
        ext_cdb_valid_i = 1'b0;
        ext_cdb_tag_i = '0;
        ext_cdb_value_i = '0;
        open_test();
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) step();
        close_test("reset");

        open_test();
        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 3; j++) begin
                dispatch(cmp_op_e'(k), rob_tag_t'(j), 1'b1, 3'd0, edge_value(),
                    1'b1, 3'd0, edge_value());
                wait_results(1);
            end
        end
        close_test("ready operands");

        open_test();
        dispatch(blt, 3'd0, 1'b0, 3'd5, 32'h0, 1'b1, 3'd0, 32'hffff_fff0);
        dispatch(bgeu, 3'd1, 1'b0, 3'd6, 32'h0, 1'b0, 3'd5, 32'h0);
        dispatch(bltu, 3'd2, 1'b0, 3'd4, 32'h0, 1'b1, 3'd0, 32'h10);
        bcast_now(3'd4, 32'h3);
        repeat (3) step();
        broadcast(3'd5, 32'h8000_0001);
        broadcast(3'd6, 32'h9000_0000);
        wait_results(3);
        close_test("external wakeup");

        open_test();
        dispatch(beq, 3'd3, 1'b1, 3'd0, 32'h5, 1'b1, 3'd0, 32'h5);
        dispatch(bne, 3'd4, 1'b0, 3'd3, 32'h0, 1'b1, 3'd0, 32'h1);
        dispatch(slt, 3'd5, 1'b1, 3'd0, 32'h0, 1'b0, 3'd4, 32'h0);
        wait_results(3);
        close_test("own lane chaining");

        open_test();
        for (int d = 0; d < 4; d++) begin
            dispatch(blt, rob_tag_t'(d), 1'b0, 3'd7, 32'h0, 1'b1, 3'd0, rv32i_word'(d));
        end
        seen = 0;
        while (!full_o && seen < 10) begin
            step();
            seen++;
        end
        if (!full_o) begin
            tb_errs++;
            $display("full_o stayed low with four operations waiting");
        end
        broadcast(3'd7, 32'h2);
        wait_results(4);
        step();
        if (full_o) begin
            tb_errs++;
            $display("full_o still high after the station drained");
        end
        close_test("full and drain");

        open_test();
        dispatch(bge, 3'd0, 1'b0, 3'd6, 32'h0, 1'b1, 3'd0, 32'h4);
        dispatch(bne, 3'd1, 1'b1, 3'd0, 32'h9, 1'b0, 3'd6, 32'h0);
        step();
        flush_i <= 1'b1;
        broadcast(3'd6, 32'h5);
        seen = result_cnt;
        repeat (8) step();
        if (result_cnt != seen) begin
            tb_errs++;
            $display("a flushed operation still produced a result");
        end
        dispatch(sltu, 3'd2, 1'b1, 3'd0, 32'h1, 1'b1, 3'd0, 32'hffff_ffff);
        dispatch(bgeu, 3'd3, 1'b1, 3'd0, 32'h7, 1'b1, 3'd0, 32'h7);
        wait_results(2);
        close_test("flush");

        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
            n_pass + n_fail, n_pass, n_fail, u_dut.u_checker.fail_cnt);
        if (n_fail == 0 && u_dut.u_checker.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit grows with the number of tests
    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired at %0t, run did not finish", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== cmp_cluster_checker.sv ====
`include "ooo_defs.svh"

module cmp_cluster_checker
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input logic      flush_i,
    input logic      disp_valid_i,
    input cmp_op_e   disp_op_i,
    input rob_tag_t  disp_dst_tag_i,
    input logic      disp_src1_ready_i,
    input rob_tag_t  disp_src1_tag_i,
    input rv32i_word disp_src1_value_i,
    input logic      disp_src2_ready_i,
    input rob_tag_t  disp_src2_tag_i,
    input rv32i_word disp_src2_value_i,
    input logic      ext_cdb_valid_i,
    input rob_tag_t  ext_cdb_tag_i,
    input rv32i_word ext_cdb_value_i,
    input logic      full_o,
    input logic      cdb_valid_o,
    input rob_tag_t  cdb_tag_o,
    input rv32i_word cdb_value_o
);

    localparam int NTAGS = 1 << `ROB_TAG_W;

    // expected state per destination tag
    logic      pend_q [NTAGS];
    logic      fast_q [NTAGS];
    int        dcyc_q [NTAGS];
    cmp_op_e   op_q   [NTAGS];
    logic      r1_q   [NTAGS];
    rob_tag_t  t1_q   [NTAGS];
    rv32i_word v1_q   [NTAGS];
    logic      r2_q   [NTAGS];
    rob_tag_t  t2_q   [NTAGS];
    rv32i_word v2_q   [NTAGS];
    int        cyc = 0;
    int        pend_cnt;
    int        fail_cnt = 0;
    rv32i_word exp_value;

    function automatic logic compare_rule(cmp_op_e op, rv32i_word a, rv32i_word b);
        rv32i_word sign;
        logic      eq;
        logic      lt_u;
        logic      lt_s;
        sign = rv32i_word'(1) << (`XLEN - 1);
        eq   = (a == b);
        lt_u = (a < b);
        // flipping the sign bit maps two's complement order onto unsigned order
        lt_s = ((a ^ sign) < (b ^ sign));
        case (op)
            beq:        return eq;
            bne:        return !eq;
            blt, slt:   return lt_s;
            bge:        return !lt_s;
            bltu, sltu: return lt_u;
            default:    return !lt_u;
        endcase
    endfunction

    always_comb begin
        pend_cnt = 0;
        for (int t = 0; t < NTAGS; t++) begin
            pend_cnt += int'(pend_q[t]);
        end
        exp_value = {{(`XLEN - 1){1'b0}},
            compare_rule(op_q[cdb_tag_o], v1_q[cdb_tag_o], v2_q[cdb_tag_o])};
    end

    always_ff @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst_n_i || flush_i) begin
            for (int t = 0; t < NTAGS; t++) begin
                pend_q[t] <= 1'b0;
            end
        end else begin
            // wake waiting sources with the external lane taking priority
            for (int t = 0; t < NTAGS; t++) begin
                if (!r1_q[t] && ext_cdb_valid_i && ext_cdb_tag_i == t1_q[t]) begin
                    r1_q[t] <= 1'b1;
                    v1_q[t] <= ext_cdb_value_i;
                end else if (!r1_q[t] && cdb_valid_o && cdb_tag_o == t1_q[t]) begin
                    r1_q[t] <= 1'b1;
                    v1_q[t] <= exp_value;
                end
                if (!r2_q[t] && ext_cdb_valid_i && ext_cdb_tag_i == t2_q[t]) begin
                    r2_q[t] <= 1'b1;
                    v2_q[t] <= ext_cdb_value_i;
                end else if (!r2_q[t] && cdb_valid_o && cdb_tag_o == t2_q[t]) begin
                    r2_q[t] <= 1'b1;
                    v2_q[t] <= exp_value;
                end
            end
            if (cdb_valid_o) begin
                pend_q[cdb_tag_o] <= 1'b0;
            end
            if (disp_valid_i) begin
                pend_q[disp_dst_tag_i] <= 1'b1;
                op_q[disp_dst_tag_i]   <= disp_op_i;
                dcyc_q[disp_dst_tag_i] <= cyc;
                // idle station and both values at hand gives the fixed latency
                fast_q[disp_dst_tag_i] <= disp_src1_ready_i && disp_src2_ready_i
                    && (pend_cnt == 0);
                t1_q[disp_dst_tag_i] <= disp_src1_tag_i;
                t2_q[disp_dst_tag_i] <= disp_src2_tag_i;
                r1_q[disp_dst_tag_i] <= 1'b1;
                r2_q[disp_dst_tag_i] <= 1'b1;
                if (disp_src1_ready_i) begin
                    v1_q[disp_dst_tag_i] <= disp_src1_value_i;
                end else if (ext_cdb_valid_i && ext_cdb_tag_i == disp_src1_tag_i) begin
                    v1_q[disp_dst_tag_i] <= ext_cdb_value_i;
                end else if (cdb_valid_o && cdb_tag_o == disp_src1_tag_i) begin
                    v1_q[disp_dst_tag_i] <= exp_value;
                end else begin
                    r1_q[disp_dst_tag_i] <= 1'b0;
                end
                if (disp_src2_ready_i) begin
                    v2_q[disp_dst_tag_i] <= disp_src2_value_i;
                end else if (ext_cdb_valid_i && ext_cdb_tag_i == disp_src2_tag_i) begin
                    v2_q[disp_dst_tag_i] <= ext_cdb_value_i;
                end else if (cdb_valid_o && cdb_tag_o == disp_src2_tag_i) begin
                    v2_q[disp_dst_tag_i] <= exp_value;
                end else begin
                    r2_q[disp_dst_tag_i] <= 1'b0;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !cdb_valid_o && !full_o)
        else begin
            fail_cnt++;
            $error("result lane or full flag active right after reset");
        end

    a_flush_quiet: assert property (@(posedge clk) rst_n_i && flush_i |=> !cdb_valid_o && !full_o)
        else begin
            fail_cnt++;
            $error("result lane or full flag active right after flush");
        end

    a_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o |-> pend_q[cdb_tag_o])
        else begin
            fail_cnt++;
            $error("result on tag %0d with no operation waiting for it", cdb_tag_o);
        end

    a_operands_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o && pend_q[cdb_tag_o] |-> r1_q[cdb_tag_o] && r2_q[cdb_tag_o])
        else begin
            fail_cnt++;
            $error("result on tag %0d before its operands were broadcast", cdb_tag_o);
        end

    a_value: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o && pend_q[cdb_tag_o] |-> cdb_value_o == exp_value)
        else begin
            fail_cnt++;
            $error("mismatch at %0t: cdb_value_o expected %h actual %h",
                $time, exp_value, cdb_value_o);
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_valid_o && pend_q[cdb_tag_o] && fast_q[cdb_tag_o]
            |-> cyc == dcyc_q[cdb_tag_o] + 4)
        else begin
            fail_cnt++;
            $error("mismatch at %0t: cdb_valid_o latency expected 4 actual %0d",
                $time, cyc - dcyc_q[cdb_tag_o]);
        end

endmodule

// ==== cmp_cluster.sv ====
`include "ooo_defs.svh"

module cmp_cluster
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,

    input  logic      disp_valid_i,
    input  cmp_op_e   disp_op_i,
    input  rob_tag_t  disp_dst_tag_i,
    input  logic      disp_src1_ready_i,
    input  rob_tag_t  disp_src1_tag_i,
    input  rv32i_word disp_src1_value_i,
    input  logic      disp_src2_ready_i,
    input  rob_tag_t  disp_src2_tag_i,
    input  rv32i_word disp_src2_value_i,

    input  logic      ext_cdb_valid_i,
    input  rob_tag_t  ext_cdb_tag_i,
    input  rv32i_word ext_cdb_value_i,

    output logic      full_o,
    output logic      cdb_valid_o,
    output rob_tag_t  cdb_tag_o,
    output rv32i_word cdb_value_o
);

    // fetch to station
    logic      fetch_valid;
    cmp_op_e   fetch_op;
    rob_tag_t  fetch_dst_tag;
    logic      fetch_src1_ready;
    rob_tag_t  fetch_src1_tag;
    rv32i_word fetch_src1_value;
    logic      fetch_src2_ready;
    rob_tag_t  fetch_src2_tag;
    rv32i_word fetch_src2_value;

    // station to comparator
    logic      issue_valid;
    cmp_op_e   issue_op;
    rv32i_word issue_a;
    rv32i_word issue_b;
    rob_tag_t  issue_dst_tag;

    operand_fetch u_fetch (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .disp_valid_i       (disp_valid_i),
        .disp_op_i          (disp_op_i),
        .disp_dst_tag_i     (disp_dst_tag_i),
        .disp_src1_ready_i  (disp_src1_ready_i),
        .disp_src1_tag_i    (disp_src1_tag_i),
        .disp_src1_value_i  (disp_src1_value_i),
        .disp_src2_ready_i  (disp_src2_ready_i),
        .disp_src2_tag_i    (disp_src2_tag_i),
        .disp_src2_value_i  (disp_src2_value_i),
        .ext_cdb_valid_i    (ext_cdb_valid_i),
        .ext_cdb_tag_i      (ext_cdb_tag_i),
        .ext_cdb_value_i    (ext_cdb_value_i),
        // own result lane looped back for wakeup
        .own_cdb_valid_i    (cdb_valid_o),
        .own_cdb_tag_i      (cdb_tag_o),
        .own_cdb_value_i    (cdb_value_o),
        .fetch_valid_o      (fetch_valid),
        .fetch_op_o         (fetch_op),
        .fetch_dst_tag_o    (fetch_dst_tag),
        .fetch_src1_ready_o (fetch_src1_ready),
        .fetch_src1_tag_o   (fetch_src1_tag),
        .fetch_src1_value_o (fetch_src1_value),
        .fetch_src2_ready_o (fetch_src2_ready),
        .fetch_src2_tag_o   (fetch_src2_tag),
        .fetch_src2_value_o (fetch_src2_value)
    );

    cmp_rs u_rs (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .fetch_valid_i      (fetch_valid),
        .fetch_op_i         (fetch_op),
        .fetch_dst_tag_i    (fetch_dst_tag),
        .fetch_src1_ready_i (fetch_src1_ready),
        .fetch_src1_tag_i   (fetch_src1_tag),
        .fetch_src1_value_i (fetch_src1_value),
        .fetch_src2_ready_i (fetch_src2_ready),
        .fetch_src2_tag_i   (fetch_src2_tag),
        .fetch_src2_value_i (fetch_src2_value),
        .ext_cdb_valid_i    (ext_cdb_valid_i),
        .ext_cdb_tag_i      (ext_cdb_tag_i),
        .ext_cdb_value_i    (ext_cdb_value_i),
        .own_cdb_valid_i    (cdb_valid_o),
        .own_cdb_tag_i      (cdb_tag_o),
        .own_cdb_value_i    (cdb_value_o),
        .full_o             (full_o),
        .issue_valid_o      (issue_valid),
        .issue_op_o         (issue_op),
        .issue_a_o          (issue_a),
        .issue_b_o          (issue_b),
        .issue_dst_tag_o    (issue_dst_tag)
    );

    cmp_unit u_cmp (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid),
        .issue_op_i      (issue_op),
        .issue_a_i       (issue_a),
        .issue_b_i       (issue_b),
        .issue_dst_tag_i (issue_dst_tag),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_tag_o       (cdb_tag_o),
        .cdb_value_o     (cdb_value_o)
    );

endmodule

// ==== cmp_unit.sv ====
`include "ooo_defs.svh"

module cmp_unit
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,

    input  logic      issue_valid_i,
    input  cmp_op_e   issue_op_i,
    input  rv32i_word issue_a_i,
    input  rv32i_word issue_b_i,
    input  rob_tag_t  issue_dst_tag_i,

    output logic      cdb_valid_o,
    output rob_tag_t  cdb_tag_o,
    output rv32i_word cdb_value_o
);

    logic res;

    always_comb begin
        case (issue_op_i)
            beq:        res = (issue_a_i == issue_b_i);
            bne:        res = (issue_a_i != issue_b_i);
            blt, slt:   res = ($signed(issue_a_i) < $signed(issue_b_i));
            bge:        res = ($signed(issue_a_i) >= $signed(issue_b_i));
            bltu, sltu: res = (issue_a_i < issue_b_i);
            bgeu:       res = (issue_a_i >= issue_b_i);
            default:    res = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= issue_valid_i;
        end
    end

    // result lane payload, flag zero-extended to a word
    always_ff @(posedge clk) begin
        cdb_tag_o   <= issue_dst_tag_i;
        cdb_value_o <= {{(`XLEN - 1){1'b0}}, res};
    end

endmodule

// ==== cmp_rs.sv ====
`include "ooo_defs.svh"

module cmp_rs
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,

    input  logic      fetch_valid_i,
    input  cmp_op_e   fetch_op_i,
    input  rob_tag_t  fetch_dst_tag_i,
    input  logic      fetch_src1_ready_i,
    input  rob_tag_t  fetch_src1_tag_i,
    input  rv32i_word fetch_src1_value_i,
    input  logic      fetch_src2_ready_i,
    input  rob_tag_t  fetch_src2_tag_i,
    input  rv32i_word fetch_src2_value_i,

    input  logic      ext_cdb_valid_i,
    input  rob_tag_t  ext_cdb_tag_i,
    input  rv32i_word ext_cdb_value_i,
    input  logic      own_cdb_valid_i,
    input  rob_tag_t  own_cdb_tag_i,
    input  rv32i_word own_cdb_value_i,

    output logic      full_o,
    output logic      issue_valid_o,
    output cmp_op_e   issue_op_o,
    output rv32i_word issue_a_o,
    output rv32i_word issue_b_o,
    output rob_tag_t  issue_dst_tag_o
);

    localparam int N     = `CMP_RS_SIZE;
    localparam int CNT_W = $clog2(N + 1);

    // station entries
    logic [N-1:0] busy_q;
    cmp_op_e      op_q   [N];
    rob_tag_t     dst_q  [N];
    logic         rdy1_q [N];
    rob_tag_t     tag1_q [N];
    rv32i_word    val1_q [N];
    logic         rdy2_q [N];
    rob_tag_t     tag2_q [N];
    rv32i_word    val2_q [N];

    // operands after this cycle's bus snoop
    logic         rdy1_c [N];
    rv32i_word    val1_c [N];
    logic         rdy2_c [N];
    rv32i_word    val2_c [N];

    logic         in_rdy1;
    rv32i_word    in_val1;
    logic         in_rdy2;
    rv32i_word    in_val2;

    logic [N-1:0] cand;
    logic         issue_hit;
    rs_idx_t      issue_idx;
    logic         alloc_hit;
    rs_idx_t      alloc_idx;
    logic [N-1:0] busy_d;
    logic [CNT_W-1:0] free_cnt;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            {rdy1_c[i], val1_c[i]} = cdb_snoop(rdy1_q[i], tag1_q[i], val1_q[i],
                ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
                own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
            {rdy2_c[i], val2_c[i]} = cdb_snoop(rdy2_q[i], tag2_q[i], val2_q[i],
                ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
                own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
            // a broadcast this cycle already counts, so wakeup issues next edge
            cand[i] = busy_q[i] && rdy1_c[i] && rdy2_c[i];
        end
        // incoming op snoops too, nothing slips between fetch and station
        {in_rdy1, in_val1} = cdb_snoop(fetch_src1_ready_i, fetch_src1_tag_i,
            fetch_src1_value_i, ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
            own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
        {in_rdy2, in_val2} = cdb_snoop(fetch_src2_ready_i, fetch_src2_tag_i,
            fetch_src2_value_i, ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
            own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
    end

    // lowest index wins for both issue and allocation
    always_comb begin
        issue_hit = 1'b0;
        issue_idx = '0;
        alloc_hit = 1'b0;
        alloc_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (cand[i]) begin
                issue_hit = 1'b1;
                issue_idx = rs_idx_t'(i);
            end
            if (!busy_q[i]) begin
                alloc_hit = 1'b1;
                alloc_idx = rs_idx_t'(i);
            end
        end
    end

    // occupancy after this edge
    always_comb begin
        busy_d = busy_q;
        if (issue_hit) begin
            busy_d[issue_idx] = 1'b0;
        end
        // with no free slot the op is dropped
        if (fetch_valid_i && alloc_hit) begin
            busy_d[alloc_idx] = 1'b1;
        end
        free_cnt = '0;
        for (int i = 0; i < N; i++) begin
            free_cnt = free_cnt + {{(CNT_W - 1){1'b0}}, ~busy_d[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q        <= '0;
            issue_valid_o <= 1'b0;
            full_o        <= 1'b0;
        end else begin
            busy_q        <= busy_d;
            issue_valid_o <= issue_hit;
            // keep one slot back for the op that may be entering fetch now
            full_o        <= (free_cnt < 2);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            rdy1_q[i] <= rdy1_c[i];
            val1_q[i] <= val1_c[i];
            rdy2_q[i] <= rdy2_c[i];
            val2_q[i] <= val2_c[i];
        end
        if (fetch_valid_i && alloc_hit) begin
            op_q[alloc_idx]   <= fetch_op_i;
            dst_q[alloc_idx]  <= fetch_dst_tag_i;
            rdy1_q[alloc_idx] <= in_rdy1;
            tag1_q[alloc_idx] <= fetch_src1_tag_i;
            val1_q[alloc_idx] <= in_val1;
            rdy2_q[alloc_idx] <= in_rdy2;
            tag2_q[alloc_idx] <= fetch_src2_tag_i;
            val2_q[alloc_idx] <= in_val2;
        end
        issue_op_o      <= op_q[issue_idx];
        issue_a_o       <= val1_c[issue_idx];
        issue_b_o       <= val2_c[issue_idx];
        issue_dst_tag_o <= dst_q[issue_idx];
    end

endmodule

// ==== operand_fetch.sv ====
`include "ooo_defs.svh"

module operand_fetch
    import rv32i_types_pkg::*;
    import ooo_structs_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,

    input  logic      disp_valid_i,
    input  cmp_op_e   disp_op_i,
    input  rob_tag_t  disp_dst_tag_i,
    input  logic      disp_src1_ready_i,
    input  rob_tag_t  disp_src1_tag_i,
    input  rv32i_word disp_src1_value_i,
    input  logic      disp_src2_ready_i,
    input  rob_tag_t  disp_src2_tag_i,
    input  rv32i_word disp_src2_value_i,

    input  logic      ext_cdb_valid_i,
    input  rob_tag_t  ext_cdb_tag_i,
    input  rv32i_word ext_cdb_value_i,
    input  logic      own_cdb_valid_i,
    input  rob_tag_t  own_cdb_tag_i,
    input  rv32i_word own_cdb_value_i,

    output logic      fetch_valid_o,
    output cmp_op_e   fetch_op_o,
    output rob_tag_t  fetch_dst_tag_o,
    output logic      fetch_src1_ready_o,
    output rob_tag_t  fetch_src1_tag_o,
    output rv32i_word fetch_src1_value_o,
    output logic      fetch_src2_ready_o,
    output rob_tag_t  fetch_src2_tag_o,
    output rv32i_word fetch_src2_value_o
);

    logic      src1_ready_d;
    rv32i_word src1_value_d;
    logic      src2_ready_d;
    rv32i_word src2_value_d;

    // catch a broadcast that lands while the op is still in dispatch
    always_comb begin
        {src1_ready_d, src1_value_d} = cdb_snoop(disp_src1_ready_i, disp_src1_tag_i,
            disp_src1_value_i, ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
            own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
        {src2_ready_d, src2_value_d} = cdb_snoop(disp_src2_ready_i, disp_src2_tag_i,
            disp_src2_value_i, ext_cdb_valid_i, ext_cdb_tag_i, ext_cdb_value_i,
            own_cdb_valid_i, own_cdb_tag_i, own_cdb_value_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= disp_valid_i;
        end
    end

    // operation payload, only loaded on a strobe
    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            fetch_op_o         <= disp_op_i;
            fetch_dst_tag_o    <= disp_dst_tag_i;
            fetch_src1_ready_o <= src1_ready_d;
            fetch_src1_tag_o   <= disp_src1_tag_i;
            fetch_src1_value_o <= src1_value_d;
            fetch_src2_ready_o <= src2_ready_d;
            fetch_src2_tag_o   <= disp_src2_tag_i;
            fetch_src2_value_o <= src2_value_d;
        end
    end

endmodule

// ==== ooo_structs_pkg.sv ====
`include "ooo_defs.svh"

package ooo_structs_pkg;

    import rv32i_types_pkg::*;

    // names the producer of a result in the reorder buffer
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // points at one reservation station entry
    typedef logic [$clog2(`CMP_RS_SIZE)-1:0] rs_idx_t;

    // operand wakeup from two bus lanes, returns {ready, value}
    // external lane has priority when both lanes carry the same tag
    function automatic logic [`XLEN:0] cdb_snoop(
        input logic      ready,
        input rob_tag_t  tag,
        input rv32i_word value,
        input logic      ext_valid,
        input rob_tag_t  ext_tag,
        input rv32i_word ext_value,
        input logic      own_valid,
        input rob_tag_t  own_tag,
        input rv32i_word own_value
    );
        if (ready) begin
            return {1'b1, value};
        end else if (ext_valid && (ext_tag == tag)) begin
            return {1'b1, ext_value};
        end else if (own_valid && (own_tag == tag)) begin
            return {1'b1, own_value};
        end
        return {1'b0, value};
    endfunction

endpackage

// ==== rv32i_types_pkg.sv ====
`include "ooo_defs.svh"

package rv32i_types_pkg;

    // one architectural data word
    typedef logic [`XLEN-1:0] rv32i_word;

    // compare operations handled by the cluster
    // branch codes follow the funct3 field of the B-type encoding,
    // set-less-than takes the two codes that branches leave unused
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        // set-less-than, signed
        slt  = 3'b010,
        // set-less-than, unsigned
        sltu = 3'b011,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

endpackage

// ==== ooo_defs.svh ====
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// sizing of the compare cluster

// reservation station depth
`define CMP_RS_SIZE 4

// reorder-buffer tag width, 8 tags in flight
`define ROB_TAG_W 3

// architectural word width
`define XLEN 32

`endif
